//--- bench/exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_tb;
    import exec_pkg::*;

    localparam logic [31:0] SEED    = 32'h4d82_3d6a;
    localparam int          N_RAND  = 400;
    localparam int          TIMEOUT = 50;

    logic                  clk;
    logic                  rst_n;
    logic                  issue_valid;
    logic [`EXEC_XLEN-1:0] pc;
    logic [`EXEC_XLEN-1:0] num1;
    logic [`EXEC_XLEN-1:0] num2;
    logic [`EXEC_XLEN-1:0] addr_offset;
    alu_op_e               alu_op;
    cmp_op_e               cmp_op;
    exe_kind_e             exe_kind;
    branch_kind_e          branch_kind;
    logic                  predict_taken;
    logic [`EXEC_XLEN-1:0] predict_target;
    logic                  mem_write;
    logic                  mem_read;
    logic                  reg_write;
    logic [4:0]            reg_addr;
    logic                  redirect_valid;
    logic [`EXEC_XLEN-1:0] redirect_pc;
    logic                  wb_valid;
    logic [4:0]            wb_addr;
    logic [`EXEC_XLEN-1:0] wb_data;

    // next instruction for the send tasks to fill
    logic [31:0]  nx_pc;
    logic [31:0]  nx_num1;
    logic [31:0]  nx_num2;
    logic [31:0]  nx_off;
    alu_op_e      nx_alu;
    cmp_op_e      nx_cmp;
    exe_kind_e    nx_kind;
    branch_kind_e nx_bkind;
    logic         nx_pt;
    logic [31:0]  nx_ptgt;
    logic         nx_mw;
    logic         nx_mr;
    logic         nx_rw;
    logic [4:0]   nx_ra;

    logic [31:0] lfsr;
    int          cyc;
    logic        squash_next;
    logic [31:0] model_mem [`EXEC_DMEM_WORDS];
    int          wb_cyc_q[$];
    logic [4:0]  wb_addr_q[$];
    logic [31:0] wb_data_q[$];
    int          rd_cyc_q[$];
    logic [31:0] rd_pc_q[$];

    exec_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_run(input string why);
        $display("Error at time %0t: %s", $time, why);
        $display("Something failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
        $display("Something failed");
        $fatal(1, "stopping at first error");
    endtask

    // 32-bit fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] ref_result(input exe_kind_e kind, input alu_op_e op,
                                               input logic [31:0] pcv, input logic [31:0] x,
                                               input logic [31:0] y);
        int sx;
        int sy;
        sx = x;
        sy = y;
        if (kind == branch) begin
            return pcv + `EXEC_LINK_OFFSET;
        end
        case (op)
            add:     return x + y;
            sub:     return x - y;
            and_op:  return x & y;
            or_op:   return x | y;
            xor_op:  return x ^ y;
            slt:     return (sx < sy) ? 32'd1 : 32'd0;
            sll:     return x << (y % 32);
            srl:     return x >> (y % 32);
            default: return '0;
        endcase
    endfunction

    function automatic logic ref_taken(input cmp_op_e op, input logic [31:0] x,
                                       input logic [31:0] y);
        int sx;
        int sy;
        sx = x;
        sy = y;
        case (op)
            eq:      return sx == sy;
            ne:      return sx != sy;
            lt:      return sx < sy;
            ge:      return sx >= sy;
            lez:     return sx <= 0;
            gtz:     return sx > 0;
            default: return 1'b0;
        endcase
    endfunction

    // model in issue order; c is the cycle count seen at the driving edge
    task automatic model_issue(input logic v, input int c);
        logic        squashed;
        logic        mis;
        logic [31:0] tgt;
        logic [31:0] link;
        logic [31:0] ea;
        squashed    = v && squash_next;
        squash_next = 1'b0;
        if (v && !squashed) begin
            link = nx_pc + `EXEC_LINK_OFFSET;
            ea   = nx_off + nx_num2;
            mis  = 1'b0;
            tgt  = link;
            if (nx_kind == branch) begin
                case (nx_bkind)
                    b: begin
                        mis = ref_taken(nx_cmp, nx_num1, nx_num2) != nx_pt;
                        tgt = nx_pt ? link : nx_ptgt;
                    end
                    j: begin
                        mis = !nx_pt;
                        tgt = nx_ptgt;
                    end
                    jr: begin
                        mis = !nx_pt || (nx_ptgt != nx_num1);
                        tgt = nx_num1;
                    end
                    default: mis = 1'b0;
                endcase
            end
            if (mis) begin
                rd_cyc_q.push_back(c + 3);
                rd_pc_q.push_back(tgt);
                squash_next = 1'b1;
            end
            if (nx_rw) begin
                wb_cyc_q.push_back(c + 4);
                wb_addr_q.push_back(nx_ra);
                if (nx_mr) begin
                    wb_data_q.push_back(model_mem[ea[7:2]]);
                end else begin
                    wb_data_q.push_back(ref_result(nx_kind, nx_alu, nx_pc, nx_num1, nx_num2));
                end
            end
            if (nx_mw) begin
                model_mem[ea[7:2]] = nx_num1;
            end
        end
    endtask

    task automatic step(input logic v);
        @(posedge clk);
        issue_valid    <= v;
        pc             <= nx_pc;
        num1           <= nx_num1;
        num2           <= nx_num2;
        addr_offset    <= nx_off;
        alu_op         <= nx_alu;
        cmp_op         <= nx_cmp;
        exe_kind       <= nx_kind;
        branch_kind    <= nx_bkind;
        predict_taken  <= nx_pt;
        predict_target <= nx_ptgt;
        mem_write      <= nx_mw;
        mem_read       <= nx_mr;
        reg_write      <= nx_rw;
        reg_addr       <= nx_ra;
        model_issue(v, cyc);
    endtask

    task automatic clear_next();
        nx_pc    = '0;
        nx_num1  = '0;
        nx_num2  = '0;
        nx_off   = '0;
        nx_alu   = add;
        nx_cmp   = eq;
        nx_kind  = arith;
        nx_bkind = b;
        nx_pt    = 1'b0;
        nx_ptgt  = '0;
        nx_mw    = 1'b0;
        nx_mr    = 1'b0;
        nx_rw    = 1'b0;
        nx_ra    = '0;
    endtask

    task automatic idle(input int n);
        clear_next();
        repeat (n) step(1'b0);
    endtask

    task automatic send_arith(input alu_op_e op, input logic [31:0] x, input logic [31:0] y,
                              input logic rw, input logic [4:0] ra);
        clear_next();
        nx_alu  = op;
        nx_num1 = x;
        nx_num2 = y;
        nx_rw   = rw;
        nx_ra   = ra;
        step(1'b1);
    endtask

    // addr must be word aligned; split into a random aligned offset plus num2
    task automatic send_mem(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input logic [4:0] ra);
        clear_next();
        nx_kind = memory;
        nx_off  = rand_bits(32) & 32'hffff_fffc;
        nx_num2 = addr - nx_off;
        nx_num1 = data;
        nx_mw   = wr;
        nx_mr   = !wr;
        nx_rw   = !wr;
        nx_ra   = ra;
        step(1'b1);
    endtask

    task automatic send_branch(input branch_kind_e bk, input cmp_op_e op,
                               input logic [31:0] x, input logic [31:0] y, input logic pt,
                               input logic [31:0] tgt, input logic rw, input logic [4:0] ra);
        clear_next();
        nx_kind  = branch;
        nx_bkind = bk;
        nx_cmp   = op;
        nx_pc    = rand_bits(32) & 32'hffff_fffc;
        nx_num1  = x;
        nx_num2  = y;
        nx_pt    = pt;
        nx_ptgt  = tgt;
        nx_rw    = rw;
        nx_ra    = ra;
        step(1'b1);
    endtask

    // cnd picks a taken eq compare, or a jr target that matches num1
    task automatic branch_sweep(input branch_kind_e bk);
        logic [31:0] y;
        logic [31:0] tgt;
        for (int cnd = 0; cnd < 2; cnd++) begin
            for (int pt = 0; pt < 2; pt++) begin
                y   = cnd[0] ? 32'h100 : 32'h104;
                tgt = cnd[0] ? 32'h100 : 32'h200;
                send_branch(bk, eq, 32'h100, y, pt[0], tgt, 1'b1, 5'd31);
                idle(1);
            end
        end
    endtask

    task automatic send_random();
        logic [2:0]  sel;
        logic [1:0]  bk;
        logic [2:0]  op;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] tgt;
        sel = rand_bits(3);
        bk  = rand_bits(2) % 3;
        op  = rand_bits(3) % 6;
        x   = rand_bits(32);
        y   = rand_bits(1) ? x : rand_bits(32);
        tgt = rand_bits(1) ? x : (rand_bits(30) << 2);
        case (sel)
            3'd0:       idle(1);
            3'd1, 3'd2: send_arith(alu_op_e'(rand_bits(3)), x, y, rand_bits(1), rand_bits(5));
            3'd3, 3'd4: send_mem(rand_bits(1), rand_bits(30) << 2, x, rand_bits(5));
            default:    send_branch(branch_kind_e'(bk), cmp_op_e'(op), x, y, rand_bits(1),
                                    tgt, rand_bits(1), rand_bits(5));
        endcase
    endtask

    task automatic check_redirect();
        if (redirect_valid !== 1'b0) begin
            assert (rd_cyc_q.size() != 0)
                else stop_run("redirect pulse where no redirect was expected");
            assert (cyc == rd_cyc_q[0])
                else stop_run("redirect pulse came in the wrong cycle");
            assert (redirect_pc == rd_pc_q[0])
                else report_mismatch("redirect_pc", redirect_pc, rd_pc_q[0]);
            void'(rd_cyc_q.pop_front());
            void'(rd_pc_q.pop_front());
        end else if (rd_cyc_q.size() != 0) begin
            assert (cyc < rd_cyc_q[0])
                else stop_run("expected redirect pulse did not appear");
        end
    endtask

    task automatic check_wb();
        if (wb_valid !== 1'b0) begin
            assert (wb_cyc_q.size() != 0)
                else stop_run("write-back pulse where no write-back was expected");
            assert (cyc == wb_cyc_q[0])
                else stop_run("write-back pulse came in the wrong cycle");
            assert (wb_addr == wb_addr_q[0])
                else report_mismatch("wb_addr", wb_addr, wb_addr_q[0]);
            assert (wb_data == wb_data_q[0])
                else report_mismatch("wb_data", wb_data, wb_data_q[0]);
            void'(wb_cyc_q.pop_front());
            void'(wb_addr_q.pop_front());
            void'(wb_data_q.pop_front());
        end else if (wb_cyc_q.size() != 0) begin
            assert (cyc < wb_cyc_q[0])
                else stop_run("expected write-back pulse did not appear");
        end
    endtask

    // outputs are stable by the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            check_redirect();
            check_wb();
        end
    end

    task automatic wait_drained();
        int n;
        n = 0;
        while ((wb_cyc_q.size() != 0 || rd_cyc_q.size() != 0) && n < TIMEOUT) begin
            idle(1);
            n++;
        end
        assert (wb_cyc_q.size() == 0 && rd_cyc_q.size() == 0)
            else stop_run("timed out waiting for the last expected pulses");
    endtask

    initial begin
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        cyc         = 0;
        lfsr        = SEED;
        squash_next = 1'b0;
        for (int k = 0; k < `EXEC_DMEM_WORDS; k++) begin
            model_mem[k] = '0;
        end
        clear_next();
        pc             = '0;
        num1           = '0;
        num2           = '0;
        addr_offset    = '0;
        alu_op         = add;
        cmp_op         = eq;
        exe_kind       = arith;
        branch_kind    = b;
        predict_taken  = 1'b0;
        predict_target = '0;
        mem_write      = 1'b0;
        mem_read       = 1'b0;
        reg_write      = 1'b0;
        reg_addr       = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // quiet pipeline after reset
        idle(10);

        send_arith(add, 32'd7, 32'd5, 1'b1, 5'd1);
        send_arith(sub, 32'd3, 32'd9, 1'b1, 5'd2);
        send_arith(slt, 32'hffff_fff0, 32'd1, 1'b1, 5'd3);
        send_arith(sll, 32'h1, 32'd36, 1'b1, 5'd4);
        send_arith(srl, 32'h8000_0000, 32'd31, 1'b1, 5'd5);
        send_arith(xor_op, 32'hff00, 32'h0ff0, 1'b0, 5'd6);
        send_arith(and_op, 32'hf0f0, 32'hff00, 1'b1, 5'd7);
        send_arith(or_op, 32'hf0f0, 32'h0f0f, 1'b1, 5'd8);

        // store then load back to back, then an untouched word
        send_mem(1'b1, 32'h40, 32'hcafe_0001, 5'd0);
        send_mem(1'b0, 32'h40, 32'd0, 5'd9);
        send_mem(1'b0, 32'h80, 32'd0, 5'd10);
        send_mem(1'b1, 32'hfc, 32'h1234_5678, 5'd0);
        idle(1);
        send_mem(1'b0, 32'hfc, 32'd0, 5'd11);

        branch_sweep(b);
        branch_sweep(j);
        branch_sweep(jr);

        // wrong-path slot is dropped and the next one runs
        send_branch(b, eq, 32'd1, 32'd1, 1'b0, 32'h300, 1'b0, 5'd0);
        send_mem(1'b1, 32'h44, 32'hdead_beef, 5'd0);
        send_mem(1'b0, 32'h44, 32'd0, 5'd12);
        send_branch(j, eq, 32'd0, 32'd0, 1'b0, 32'h400, 1'b0, 5'd0);
        send_arith(add, 32'd1, 32'd2, 1'b1, 5'd13);
        send_arith(add, 32'd3, 32'd4, 1'b1, 5'd14);

        for (int k = 0; k < N_RAND; k++) begin
            send_random();
        end

        wait_drained();
        idle(5);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_core.f
+incdir+logic
logic/exec_pkg.sv
logic/alu.sv
logic/branch_cmp.sv
logic/issue_latch.sv
logic/fu.sv
logic/mem_stage.sv
logic/exec_top.sv
bench/exec_tb.sv

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module alu (
    input  wire logic [`EXEC_XLEN-1:0] a,
    input  wire logic [`EXEC_XLEN-1:0] b,
    input  wire exec_pkg::alu_op_e     alu_op,
    output logic [`EXEC_XLEN-1:0]      y
);
    import exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            add:     y = a + b;
            sub:     y = a - b;
            and_op:  y = a & b;
            or_op:   y = a | b;
            xor_op:  y = a ^ b;
            // signed set-less-than, zero extended
            slt:     y = {{(`EXEC_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            sll:     y = a << shamt;
            srl:     y = a >> shamt;
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/branch_cmp.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module branch_cmp (
    input  wire logic [`EXEC_XLEN-1:0] a,
    input  wire logic [`EXEC_XLEN-1:0] b,
    input  wire exec_pkg::cmp_op_e     cmp_op,
    output logic                       taken
);
    import exec_pkg::*;

    always_comb begin
        case (cmp_op)
            eq:      taken = (a == b);
            ne:      taken = (a != b);
            lt:      taken = ($signed(a) < $signed(b));
            ge:      taken = ($signed(a) >= $signed(b));
            // single operand tests
            lez:     taken = ($signed(a) <= 0);
            gtz:     taken = ($signed(a) > 0);
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath and address width
`define EXEC_XLEN 32

// data memory depth in words, indexed by address bits [7:2]
`define EXEC_DMEM_WORDS 64

// link value and branch fall-through
`define EXEC_LINK_OFFSET 8

`endif

//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef enum logic [2:0] {
        add    = 3'd0,
        sub    = 3'd1,
        and_op = 3'd2,
        or_op  = 3'd3,
        xor_op = 3'd4,
        slt    = 3'd5,
        sll    = 3'd6,
        srl    = 3'd7
    } alu_op_e;

    // all compares signed
    typedef enum logic [2:0] {
        eq  = 3'd0,
        ne  = 3'd1,
        lt  = 3'd2,
        ge  = 3'd3,
        lez = 3'd4,
        gtz = 3'd5
    } cmp_op_e;

    typedef enum logic [1:0] {
        arith  = 2'd0,
        memory = 2'd1,
        branch = 2'd2
    } exe_kind_e;

    typedef enum logic [1:0] {
        b  = 2'd0,
        j  = 2'd1,
        jr = 2'd2
    } branch_kind_e;

endpackage

`default_nettype wire

//--- logic/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module exec_top (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           issue_valid,
    input  wire logic [`EXEC_XLEN-1:0]    pc,
    input  wire logic [`EXEC_XLEN-1:0]    num1,
    input  wire logic [`EXEC_XLEN-1:0]    num2,
    input  wire logic [`EXEC_XLEN-1:0]    addr_offset,
    input  wire exec_pkg::alu_op_e        alu_op,
    input  wire exec_pkg::cmp_op_e        cmp_op,
    input  wire exec_pkg::exe_kind_e      exe_kind,
    input  wire exec_pkg::branch_kind_e   branch_kind,
    input  wire                           predict_taken,
    input  wire logic [`EXEC_XLEN-1:0]    predict_target,
    input  wire                           mem_write,
    input  wire                           mem_read,
    input  wire                           reg_write,
    input  wire logic [4:0]               reg_addr,
    output logic                          redirect_valid,
    output logic [`EXEC_XLEN-1:0]         redirect_pc,
    output logic                          wb_valid,
    output logic [4:0]                    wb_addr,
    output logic [`EXEC_XLEN-1:0]         wb_data
);
    import exec_pkg::*;

    logic                  kill;

    // issue latch to execute
    logic                  s1_valid;
    logic [`EXEC_XLEN-1:0] s1_pc;
    logic [`EXEC_XLEN-1:0] s1_num1;
    logic [`EXEC_XLEN-1:0] s1_num2;
    logic [`EXEC_XLEN-1:0] s1_addr_offset;
    alu_op_e               s1_alu_op;
    cmp_op_e               s1_cmp_op;
    exe_kind_e             s1_exe_kind;
    branch_kind_e          s1_branch_kind;
    logic                  s1_predict_taken;
    logic [`EXEC_XLEN-1:0] s1_predict_target;
    logic                  s1_mem_write;
    logic                  s1_mem_read;
    logic                  s1_reg_write;
    logic [4:0]            s1_reg_addr;

    // execute to memory stage
    logic                  s2_valid;
    logic [`EXEC_XLEN-1:0] s2_result;
    logic [`EXEC_XLEN-1:0] s2_addr;
    logic [`EXEC_XLEN-1:0] s2_store_data;
    logic                  s2_mem_write;
    logic                  s2_mem_read;
    logic                  s2_reg_write;
    logic [4:0]            s2_reg_addr;

    // port names line up stage to stage
    issue_latch u_issue (.*);

    fu u_fu (.*);

    mem_stage u_mem (.*);

endmodule

`default_nettype wire

//--- logic/fu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module fu (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           s1_valid,
    input  wire logic [`EXEC_XLEN-1:0]    s1_pc,
    input  wire logic [`EXEC_XLEN-1:0]    s1_num1,
    input  wire logic [`EXEC_XLEN-1:0]    s1_num2,
    input  wire logic [`EXEC_XLEN-1:0]    s1_addr_offset,
    input  wire exec_pkg::alu_op_e        s1_alu_op,
    input  wire exec_pkg::cmp_op_e        s1_cmp_op,
    input  wire exec_pkg::exe_kind_e      s1_exe_kind,
    input  wire exec_pkg::branch_kind_e   s1_branch_kind,
    input  wire                           s1_predict_taken,
    input  wire logic [`EXEC_XLEN-1:0]    s1_predict_target,
    input  wire                           s1_mem_write,
    input  wire                           s1_mem_read,
    input  wire                           s1_reg_write,
    input  wire logic [4:0]               s1_reg_addr,
    output logic                          kill,
    output logic                          redirect_valid,
    output logic [`EXEC_XLEN-1:0]         redirect_pc,
    output logic                          s2_valid,
    output logic [`EXEC_XLEN-1:0]         s2_result,
    output logic [`EXEC_XLEN-1:0]         s2_addr,
    output logic [`EXEC_XLEN-1:0]         s2_store_data,
    output logic                          s2_mem_write,
    output logic                          s2_mem_read,
    output logic                          s2_reg_write,
    output logic [4:0]                    s2_reg_addr
);
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0] alu_y;
    logic [`EXEC_XLEN-1:0] link_pc;
    logic [`EXEC_XLEN-1:0] mem_addr;
    logic [`EXEC_XLEN-1:0] target;
    logic                  cond;
    logic                  mispredict;

    alu u_alu (
        .a      (s1_num1),
        .b      (s1_num2),
        .alu_op (s1_alu_op),
        .y      (alu_y)
    );

    branch_cmp u_cmp (
        .a      (s1_num1),
        .b      (s1_num2),
        .cmp_op (s1_cmp_op),
        .taken  (cond)
    );

    assign link_pc  = s1_pc + `EXEC_XLEN'(`EXEC_LINK_OFFSET);
    // lw rt, imm(rs) style addressing
    assign mem_addr = s1_addr_offset + s1_num2;

    // prediction check
    always_comb begin
        mispredict = 1'b0;
        target     = link_pc;
        case (s1_branch_kind)
            b: begin
                if (cond && !s1_predict_taken) begin
                    mispredict = 1'b1;
                    target     = s1_predict_target;
                end else if (!cond && s1_predict_taken) begin
                    mispredict = 1'b1;
                    target     = link_pc;
                end
            end
            j: begin
                if (!s1_predict_taken) begin
                    mispredict = 1'b1;
                    target     = s1_predict_target;
                end
            end
            jr: begin
                if (!s1_predict_taken || s1_predict_target != s1_num1) begin
                    mispredict = 1'b1;
                    target     = s1_num1;
                end
            end
            default: begin
                mispredict = 1'b0;
            end
        endcase
    end

    assign kill = s1_valid && (s1_exe_kind == branch) && mispredict;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            redirect_valid <= 1'b0;
            s2_valid       <= 1'b0;
        end else begin
            redirect_valid <= kill;
            s2_valid       <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        redirect_pc   <= target;
        s2_result     <= (s1_exe_kind == branch) ? link_pc : alu_y;
        s2_addr       <= mem_addr;
        s2_store_data <= s1_num1;
        s2_mem_write  <= s1_mem_write;
        s2_mem_read   <= s1_mem_read;
        s2_reg_write  <= s1_reg_write;
        s2_reg_addr   <= s1_reg_addr;
    end

    a_no_read_write: assert property (@(posedge clk) disable iff (!rst_n)
        s1_valid |-> !(s1_mem_write && s1_mem_read));

endmodule

`default_nettype wire

//--- logic/issue_latch.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module issue_latch (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           issue_valid,
    input  wire                           kill,
    input  wire logic [`EXEC_XLEN-1:0]    pc,
    input  wire logic [`EXEC_XLEN-1:0]    num1,
    input  wire logic [`EXEC_XLEN-1:0]    num2,
    input  wire logic [`EXEC_XLEN-1:0]    addr_offset,
    input  wire exec_pkg::alu_op_e        alu_op,
    input  wire exec_pkg::cmp_op_e        cmp_op,
    input  wire exec_pkg::exe_kind_e      exe_kind,
    input  wire exec_pkg::branch_kind_e   branch_kind,
    input  wire                           predict_taken,
    input  wire logic [`EXEC_XLEN-1:0]    predict_target,
    input  wire                           mem_write,
    input  wire                           mem_read,
    input  wire                           reg_write,
    input  wire logic [4:0]               reg_addr,
    output logic                          s1_valid,
    output logic [`EXEC_XLEN-1:0]         s1_pc,
    output logic [`EXEC_XLEN-1:0]         s1_num1,
    output logic [`EXEC_XLEN-1:0]         s1_num2,
    output logic [`EXEC_XLEN-1:0]         s1_addr_offset,
    output exec_pkg::alu_op_e             s1_alu_op,
    output exec_pkg::cmp_op_e             s1_cmp_op,
    output exec_pkg::exe_kind_e           s1_exe_kind,
    output exec_pkg::branch_kind_e        s1_branch_kind,
    output logic                          s1_predict_taken,
    output logic [`EXEC_XLEN-1:0]         s1_predict_target,
    output logic                          s1_mem_write,
    output logic                          s1_mem_read,
    output logic                          s1_reg_write,
    output logic [4:0]                    s1_reg_addr
);
    import exec_pkg::*;

    // wrong-path slot behind a mispredict is dropped here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= issue_valid && !kill;
        end
    end

    always_ff @(posedge clk) begin
        s1_pc             <= pc;
        s1_num1           <= num1;
        s1_num2           <= num2;
        s1_addr_offset    <= addr_offset;
        s1_alu_op         <= alu_op;
        s1_cmp_op         <= cmp_op;
        s1_exe_kind       <= exe_kind;
        s1_branch_kind    <= branch_kind;
        s1_predict_taken  <= predict_taken;
        s1_predict_target <= predict_target;
        s1_mem_write      <= mem_write;
        s1_mem_read       <= mem_read;
        s1_reg_write      <= reg_write;
        s1_reg_addr       <= reg_addr;
    end

    // kill only comes from a live branch in execute
    a_kill_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        kill |-> s1_valid);

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exec_config.svh"

module mem_stage (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        s2_valid,
    input  wire logic [`EXEC_XLEN-1:0] s2_result,
    input  wire logic [`EXEC_XLEN-1:0] s2_addr,
    input  wire logic [`EXEC_XLEN-1:0] s2_store_data,
    input  wire                        s2_mem_write,
    input  wire                        s2_mem_read,
    input  wire                        s2_reg_write,
    input  wire logic [4:0]            s2_reg_addr,
    output logic                       wb_valid,
    output logic [4:0]                 wb_addr,
    output logic [`EXEC_XLEN-1:0]      wb_data
);
    import exec_pkg::*;

    localparam int IDX_W = $clog2(`EXEC_DMEM_WORDS);

    logic [`EXEC_XLEN-1:0] mem [`EXEC_DMEM_WORDS];
    logic [IDX_W-1:0]      idx;
    logic [`EXEC_XLEN-1:0] load_data;

    // word index, upper address bits ignored
    assign idx       = s2_addr[IDX_W+1:2];
    assign load_data = mem[idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `EXEC_DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (s2_valid && s2_mem_write) begin
            mem[idx] <= s2_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= s2_valid && s2_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= s2_reg_addr;
        wb_data <= s2_mem_read ? load_data : s2_result;
    end

    // word accesses only
    a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        s2_valid && (s2_mem_write || s2_mem_read) |-> s2_addr[1:0] == 2'b00);

endmodule

`default_nettype wire
